//--- dual_issue_core.f
+incdir+verification
common/rv_pkg.sv
design/instr_mem.sv
design/issue_pair.sv
design/lane/alu_branch_unit.sv
design/lane/decode_exec_lane.sv
design/reg_file.sv
design/commit_unit.sv
design/dual_issue_core.sv
verification/core_tb.sv

//--- verification/core_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random program builder and ISA model. x31 is the JALR base, and no jump
// or branch target lands inside its LUI/ADDI/JALR sequence.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int PROG_WORDS = 200;
localparam int INIT_WORDS = 31;  // Prologue sets x1..x31

typedef enum {
  KIND_ALU_R, KIND_ALU_I, KIND_LUI, KIND_AUIPC, KIND_BRANCH, KIND_JAL,
  KIND_SEQ_LUI, KIND_SEQ_ADDI, KIND_SEQ_JALR
} word_kind_e;

integer     seed = 32'hbf7e_abcb;
word_t      prog       [IMEM_WORDS];
word_kind_e kind       [PROG_WORDS];
word_t      model_regs [32];
word_t      model_pc;

// First word at or after i+1+hop that is not inside a JALR sequence
function automatic int land_after(int i, int hop);
  int t;
  t = (i + 1 + hop > PROG_WORDS - 1) ? PROG_WORDS - 1 : i + 1 + hop;
  while (kind[t] inside {KIND_SEQ_ADDI, KIND_SEQ_JALR}) t++;
  return t;
endfunction

task automatic build_program();
  int         i;
  int         pick;
  int         hop;
  int         t;
  word_t      r;
  funct3_t    f3;
  logic [6:0] f7;
  logic [11:0] imm;
  logic [12:0] boff;
  logic [20:0] joff;
  for (i = 0; i < IMEM_WORDS; i++) prog[i] = '0;
  for (i = 0; i < 32; i++) model_regs[i] = '0;
  for (i = 0; i < PROG_WORDS; i++) kind[i] = KIND_ALU_I;
  model_pc = '0;
  i = INIT_WORDS;
  while (i < PROG_WORDS - 1) begin
    pick = $unsigned($random(seed)) % 16;
    if (pick >= 14 && i + 2 < PROG_WORDS - 1) begin
      kind[i]     = KIND_SEQ_LUI;
      kind[i + 1] = KIND_SEQ_ADDI;
      kind[i + 2] = KIND_SEQ_JALR;
      i = i + 3;
    end else begin
      case (pick)
        0, 1, 2, 3, 4: kind[i] = KIND_ALU_R;
        9:             kind[i] = KIND_LUI;
        10:            kind[i] = KIND_AUIPC;
        11, 12:        kind[i] = KIND_BRANCH;
        13:            kind[i] = KIND_JAL;
        default:       kind[i] = KIND_ALU_I;
      endcase
      i++;
    end
  end
  kind[PROG_WORDS - 1] = KIND_JAL;  // Loops back to 0
  for (i = 0; i < PROG_WORDS; i++) begin
    r   = $random(seed);
    hop = $unsigned($random(seed)) % 8;
    f3  = r[14:12];
    if (i < INIT_WORDS) begin
      prog[i] = {r[31:20], 5'd0, 3'd0, reg_addr_t'(i + 1), OP_IMM};
    end else begin
      case (kind[i])
        KIND_ALU_R: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;  // SUB, SRA
          prog[i] = {f7, r[24:20], r[19:15], f3, r[11:7], OP_REG};
        end
        KIND_ALU_I: begin
          imm = r[31:20];
          if (f3 == 3'd1) imm = {7'h00, r[24:20]};
          if (f3 == 3'd5) imm = {1'b0, r[30], 5'h00, r[24:20]};  // SRLI or SRAI
          prog[i] = {imm, r[19:15], f3, r[11:7], OP_IMM};
        end
        KIND_LUI:   prog[i] = {r[31:12], r[11:7], OP_LUI};
        KIND_AUIPC: prog[i] = {r[31:12], r[11:7], OP_AUIPC};
        KIND_BRANCH: begin
          if (f3 inside {3'd2, 3'd3}) f3 = f3 | 3'd4;  // Only legal conditions
          boff = 13'((land_after(i, hop) - i) * 4);
          prog[i] = {boff[12], boff[10:5], r[24:20], r[19:15], f3, boff[4:1], boff[11],
                     OP_BRANCH};
        end
        KIND_JAL: begin
          t = (i == PROG_WORDS - 1) ? 0 : land_after(i, hop);
          joff = 21'((t - i) * 4);
          prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], r[11:7], OP_JAL};
        end
        KIND_SEQ_LUI:  prog[i] = {20'h00000, 5'd31, OP_LUI};
        KIND_SEQ_ADDI: begin
          imm = 12'(land_after(i + 1, hop) * 4);
          prog[i] = {imm, 5'd31, 3'd0, 5'd31, OP_IMM};
        end
        default: prog[i] = {12'd1, 5'd31, 3'd0, r[11:7], OP_JALR};  // Odd offset
      endcase
    end
  end
endtask

function automatic bit pairs_ok(word_t first, word_t second);
  bit rd_live;
  bit uses_rd;
  if (first[6:0] inside {OP_BRANCH, OP_JAL, OP_JALR}) return 1'b0;
  rd_live = (first[11:7] != 5'd0) && (first[6:0] inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC});
  uses_rd = ((second[6:0] inside {OP_REG, OP_IMM, OP_BRANCH, OP_JALR}) &&
             (second[19:15] == first[11:7])) ||
            ((second[6:0] inside {OP_REG, OP_BRANCH}) && (second[24:20] == first[11:7]));
  return !(rd_live && uses_rd);
endfunction

function automatic word_t alu(funct3_t f3, bit alt, word_t a, word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic bit branch_taken(funct3_t f3, word_t a, word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Executes the instruction at model_pc and reports what it should retire
task automatic step_model(output word_t exp_pc, output bit exp_write,
                          output reg_addr_t exp_rd, output word_t exp_value);
  word_t instr;
  word_t a;
  word_t imm_i;
  word_t next;
  instr     = prog[model_pc[9:2]];
  a         = model_regs[instr[19:15]];
  imm_i     = {{20{instr[31]}}, instr[31:20]};
  exp_pc    = model_pc;
  exp_rd    = instr[11:7];
  exp_write = 1'b1;
  exp_value = '0;
  next      = model_pc + 32'd4;
  case (instr[6:0])
    OP_REG:   exp_value = alu(instr[14:12], instr[30], a, model_regs[instr[24:20]]);
    OP_IMM:   exp_value = alu(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, imm_i);
    OP_LUI:   exp_value = {instr[31:12], 12'd0};
    OP_AUIPC: exp_value = model_pc + {instr[31:12], 12'd0};
    OP_JAL: begin
      exp_value = model_pc + 32'd4;
      next = model_pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
    end
    OP_JALR: begin
      exp_value = model_pc + 32'd4;
      next      = (a + imm_i) & ~32'd1;
    end
    OP_BRANCH: begin
      exp_write = 1'b0;
      if (branch_taken(instr[14:12], a, model_regs[instr[24:20]])) begin
        next = model_pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
      end
    end
    default: exp_write = 1'b0;  // No-op
  endcase
  if (exp_write && exp_rd != 5'd0) model_regs[exp_rd] = exp_value;
  model_pc = next;
endtask

`endif

//--- verification/core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loads a random program over APB, runs it and checks each retired
// instruction in order against the ISA model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module core_tb import rv_pkg::*; ();

  `include "core_model.svh"

  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 5;
  localparam int LOAD_CYCLES  = 3 * (PROG_WORDS + 1);  // Three clocks per APB write
  localparam int RUN_CYCLES   = 2000;
  localparam int HOLD_CYCLES  = 4;

  logic    clock;
  logic    reset_n;
  logic    run;
  logic    psel;
  logic    penable;
  logic    pwrite;
  word_t   paddr;
  word_t   pwdata;
  logic    pready;
  logic    pslverr;
  word_t   pc_out;
  retire_t retire [LANES];

  int checks;
  int errors;
  int test_start;
  int bundles;
  int paired;
  int redirects;
  word_t held_pc;

  dual_issue_core dut (
    .clock   (clock),
    .reset_n (reset_n),
    .run     (run),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .pslverr (pslverr),
    .pc_out  (pc_out),
    .retire  (retire)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #((RESET_CYCLES + LOAD_CYCLES + RUN_CYCLES + 100) * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic expect_word(string name, word_t got, word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apb_write(word_t addr, word_t data, logic exp_err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clock);
    penable <= 1'b1;            // Access phase
    @(negedge clock);
    expect_word("pready", word_t'(pready), 32'd1);
    expect_word("pslverr", word_t'(pslverr), word_t'(exp_err));
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_retire();
    word_t     exp_pc;
    bit        exp_write;
    reg_addr_t exp_rd;
    word_t     exp_value;
    bit        pair_exp;
    imem_index_t idx;
    idx      = model_pc[9:2];
    pair_exp = pairs_ok(prog[idx], prog[idx + imem_index_t'(1)]);
    if (!retire[0].valid) begin
      expect_word("retire[1].valid", word_t'(retire[1].valid), 32'd0);
      return;
    end
    bundles++;
    expect_word("retire[1].valid", word_t'(retire[1].valid), word_t'(pair_exp));
    if (retire[1].valid) paired++;
    for (int l = 0; l < LANES; l++) begin
      if (retire[l].valid) begin
        step_model(exp_pc, exp_write, exp_rd, exp_value);
        if (model_pc != exp_pc + 32'd4) redirects++;
        expect_word($sformatf("retire[%0d].pc", l), retire[l].pc, exp_pc);
        expect_word($sformatf("retire[%0d].write", l), word_t'(retire[l].write),
                    word_t'(exp_write));
        if (exp_write) begin
          expect_word($sformatf("retire[%0d].rd", l), word_t'(retire[l].rd), word_t'(exp_rd));
          expect_word($sformatf("retire[%0d].value", l), retire[l].value, exp_value);
        end
      end
    end
    expect_word("pc_out", pc_out, model_pc);  // Next pc after the bundle
  endtask

  task automatic report_test(string name);
    $display("test %s finished with %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  initial begin
    reset_n = 1'b0;
    run     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    checks  = 0;
    errors  = 0;
    test_start = 0;
    bundles   = 0;
    paired    = 0;
    redirects = 0;
    build_program();

    repeat (RESET_CYCLES) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    expect_word("pc_out", pc_out, 32'd0);
    expect_word("retire[0].valid", word_t'(retire[0].valid), 32'd0);
    expect_word("retire[1].valid", word_t'(retire[1].valid), 32'd0);
    report_test("reset_state");

    for (int i = 0; i < PROG_WORDS; i++) begin
      apb_write(word_t'(i * 4), prog[i], 1'b0);
    end
    apb_write(word_t'(IMEM_WORDS * 4), 32'hffff_ffff, 1'b1);  // Would alias word 0
    report_test("apb_load");

    @(posedge clock);
    run <= 1'b1;
    repeat (RUN_CYCLES) begin
      @(negedge clock);
      check_retire();
    end
    @(posedge clock);
    run <= 1'b0;
    @(negedge clock);
    check_retire();            // Bundle from the last run edge
    expect_word("retired bundles", word_t'(bundles), word_t'(RUN_CYCLES));
    checks++;
    assert (paired > 0 && redirects > 0) else begin
      errors++;
      $display("the program never issued a pair or never redirected");
    end
    $display("run_program: %0d bundles, %0d pairs, %0d redirects", bundles, paired, redirects);
    report_test("run_program");

    held_pc = pc_out;
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      expect_word("pc_out", pc_out, held_pc);
      expect_word("retire[0].valid", word_t'(retire[0].valid), 32'd0);
      expect_word("retire[1].valid", word_t'(retire[1].valid), 32'd0);
    end
    report_test("run_hold");

    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- design/dual_issue_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One bundle per clock while run is high. Program loads over APB only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dual_issue_core import rv_pkg::*; (
  input  logic    clock,
  input  logic    reset_n,
  input  logic    run,
  input  logic    psel,
  input  logic    penable,
  input  logic    pwrite,
  input  word_t   paddr,
  input  word_t   pwdata,
  output logic    pready,
  output logic    pslverr,
  output word_t   pc_out,
  output retire_t retire [LANES]
);

  word_t            pc;
  word_t            fetch_words [LANES];
  issue_slot_t      slots       [LANES];
  read_req_t        read_reqs   [LANES];
  word_t            read_data   [2*LANES];
  lane_result_t     results     [LANES];
  logic [LANES-1:0] write_en;
  reg_addr_t        write_addr  [LANES];
  word_t            write_data  [LANES];

  assign pc_out = pc;

  instr_mem u_imem (
    .clock       (clock),
    .reset_n     (reset_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .fetch_pc    (pc),
    .fetch_words (fetch_words)
  );

  issue_pair u_issue (
    .fetch_words (fetch_words),
    .pc          (pc),
    .run         (run),
    .slots       (slots)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    word_t rs_data [2];

    assign rs_data[0] = read_data[2*g];    // rs1
    assign rs_data[1] = read_data[2*g+1];  // rs2

    decode_exec_lane u_lane (
      .slot     (slots[g]),
      .read_req (read_reqs[g]),
      .rs_data  (rs_data),
      .result   (results[g])
    );
  end

  reg_file u_regs (
    .clock      (clock),
    .read_reqs  (read_reqs),
    .read_data  (read_data),
    .write_en   (write_en),
    .write_addr (write_addr),
    .write_data (write_data)
  );

  commit_unit u_commit (
    .clock      (clock),
    .reset_n    (reset_n),
    .run        (run),
    .slots      (slots),
    .results    (results),
    .write_en   (write_en),
    .write_addr (write_addr),
    .write_data (write_data),
    .pc         (pc),
    .retire     (retire)
  );

endmodule

//--- design/commit_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc holds while run is low. Retire report lags its bundle by one clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module commit_unit import rv_pkg::*; (
  input  logic             clock,
  input  logic             reset_n,
  input  logic             run,
  input  issue_slot_t      slots      [LANES],
  input  lane_result_t     results    [LANES],
  output logic [LANES-1:0] write_en,
  output reg_addr_t        write_addr [LANES],
  output word_t            write_data [LANES],
  output word_t            pc,
  output retire_t          retire     [LANES]
);

  word_t next_pc;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      write_en[l]   = slots[l].valid && results[l].write_en;
      write_addr[l] = results[l].rd;
      write_data[l] = results[l].wdata;
    end
  end

  // Only the last issued lane may redirect
  always_comb begin
    if (slots[1].valid) begin
      next_pc = results[1].redirect ? results[1].target : pc + 32'd8;
    end else begin
      next_pc = results[0].redirect ? results[0].target : pc + 32'd4;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
      for (int l = 0; l < LANES; l++) begin
        retire[l].valid <= 1'b0;
      end
    end else begin
      if (run) begin
        pc <= next_pc;
      end
      for (int l = 0; l < LANES; l++) begin
        retire[l].valid <= slots[l].valid;
        retire[l].pc    <= slots[l].pc;
        retire[l].write <= write_en[l];
        retire[l].rd    <= write_addr[l];
        retire[l].value <= write_data[l];
      end
    end
  end

  // Targets come from the lanes with only bit 0 cleared
  assert property (@(posedge clock) disable iff (!reset_n) pc[1:0] == 2'b00)
    else $error("commit_unit: pc lost word alignment, pc=%h", pc);

endmodule

//--- design/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads see the old value in the write cycle. Higher lane wins on rd.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic             clock,
  input  read_req_t        read_reqs  [LANES],
  output word_t            read_data  [2*LANES],
  input  logic [LANES-1:0] write_en,
  input  reg_addr_t        write_addr [LANES],
  input  word_t            write_data [LANES]
);

  localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

  word_t regs [NUM_REGS];

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      read_data[2*l]   = (read_reqs[l].rs1 == '0) ? '0 : regs[read_reqs[l].rs1];
      read_data[2*l+1] = (read_reqs[l].rs2 == '0) ? '0 : regs[read_reqs[l].rs2];
    end
  end

  always_ff @(posedge clock) begin
    for (int l = 0; l < LANES; l++) begin
      if (write_en[l] && (write_addr[l] != '0)) begin
        regs[write_addr[l]] <= write_data[l];  // Last lane in loop order wins
      end
    end
  end

endmodule

//--- design/lane/decode_exec_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unknown opcodes and M-extension encodings act as no-ops.
// Misaligned JALR targets are not trapped, only bit 0 is cleared.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module decode_exec_lane import rv_pkg::*; (
  input  issue_slot_t  slot,
  output read_req_t    read_req,
  input  word_t        rs_data [2],
  output lane_result_t result
);

  word_t   instr;
  opcode_t opcode;
  funct3_t funct3;
  word_t   imm;
  word_t   operand_a;
  word_t   operand_b;
  word_t   alu_result;
  alu_op_e alu_op;
  logic    is_jump;
  logic    is_branch;
  logic    condition;

  assign instr     = slot.instr;
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign is_jump   = opcode inside {OP_JAL, OP_JALR};
  assign is_branch = opcode == OP_BRANCH;

  assign read_req.rs1 = instr[19:15];
  assign read_req.rs2 = instr[24:20];

  always_comb begin
    case (opcode)
      OP_IMM, OP_JALR:  imm = {{20{instr[31]}}, instr[31:20]};
      OP_BRANCH:        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
      OP_JAL:           imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
      default:          imm = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_BRANCH, OP_AUIPC, OP_JAL: operand_a = slot.pc;
      OP_LUI:                      operand_a = '0;
      default:                     operand_a = rs_data[0];
    endcase
  end

  assign operand_b = (opcode == OP_REG) ? rs_data[1] : imm;

  always_comb begin
    alu_op = ALU_NONE;
    case (opcode)
      OP_REG, OP_IMM: begin
        case (funct3)
          3'b000:  alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL;  // SRAI keys on bit 30 too
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
        if (opcode == OP_REG && instr[25]) begin
          alu_op = ALU_NONE;                                // MUL/DIV space
        end
      end
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH: alu_op = ALU_ADD;
      default: alu_op = ALU_NONE;
    endcase
  end

  alu_branch_unit u_alu (
    .op        (alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .rs1_value (rs_data[0]),
    .rs2_value (rs_data[1]),
    .funct3    (funct3),
    .result    (alu_result),
    .condition (condition)
  );

  // Adder output doubles as branch and jump target
  always_comb begin
    result.write_en = slot.valid && (alu_op != ALU_NONE) && !is_branch;
    result.rd       = instr[11:7];
    result.wdata    = is_jump ? slot.pc + 32'd4 : alu_result;
    result.redirect = slot.valid && (is_jump || (is_branch && condition));
    result.target   = {alu_result[XLEN-1:1], 1'b0};
  end

endmodule

//--- design/lane/alu_branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Condition is valid only for branch encodings; callers qualify it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module alu_branch_unit import rv_pkg::*; (
  input  alu_op_e op,
  input  word_t   operand_a,
  input  word_t   operand_b,
  input  word_t   rs1_value,
  input  word_t   rs2_value,
  input  funct3_t funct3,
  output word_t   result,
  output logic    condition
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = operand_a + operand_b;
      ALU_SUB:  result = operand_a - operand_b;
      ALU_SLL:  result = operand_a << shamt;
      ALU_SLT:  result = word_t'($signed(operand_a) < $signed(operand_b));
      ALU_SLTU: result = word_t'(operand_a < operand_b);
      ALU_XOR:  result = operand_a ^ operand_b;
      ALU_SRL:  result = operand_a >> shamt;
      ALU_SRA:  result = $signed(operand_a) >>> shamt;
      ALU_OR:   result = operand_a | operand_b;
      ALU_AND:  result = operand_a & operand_b;
      default:  result = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  condition = rs1_value == rs2_value;                   // BEQ
      3'b001:  condition = rs1_value != rs2_value;                   // BNE
      3'b100:  condition = $signed(rs1_value) < $signed(rs2_value);  // BLT
      3'b101:  condition = $signed(rs1_value) >= $signed(rs2_value); // BGE
      3'b110:  condition = rs1_value < rs2_value;                    // BLTU
      3'b111:  condition = rs1_value >= rs2_value;                   // BGEU
      default: condition = 1'b0;
    endcase
  end

endmodule

//--- design/issue_pair.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second word issues only behind a non-control word with no RAW hazard.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module issue_pair import rv_pkg::*; (
  input  word_t       fetch_words [LANES],
  input  word_t       pc,
  input  logic        run,
  output issue_slot_t slots [LANES]
);

  opcode_t   op_first;
  opcode_t   op_second;
  reg_addr_t rd_first;
  reg_addr_t rs1_second;
  reg_addr_t rs2_second;
  logic      ctrl_first;
  logic      writes_first;
  logic      reads_rs1;
  logic      reads_rs2;
  logic      hazard;
  opcode_t   slot0_op;

  assign op_first   = fetch_words[0][6:0];
  assign rd_first   = fetch_words[0][11:7];
  assign op_second  = fetch_words[1][6:0];
  assign rs1_second = fetch_words[1][19:15];
  assign rs2_second = fetch_words[1][24:20];

  assign ctrl_first   = op_first inside {OP_BRANCH, OP_JAL, OP_JALR};
  assign writes_first = (rd_first != '0) &&
                        (op_first inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR});
  assign reads_rs1    = op_second inside {OP_REG, OP_IMM, OP_BRANCH, OP_JALR};
  assign reads_rs2    = op_second inside {OP_REG, OP_BRANCH};

  assign hazard = writes_first &&
                  ((reads_rs1 && (rs1_second == rd_first)) ||
                   (reads_rs2 && (rs2_second == rd_first)));

  always_comb begin
    slots[0].valid = run;
    slots[0].instr = fetch_words[0];
    slots[0].pc    = pc;
    slots[1].valid = run && !ctrl_first && !hazard;
    slots[1].instr = fetch_words[1];
    slots[1].pc    = pc + 32'd4;
  end

  assign slot0_op = slots[0].instr[6:0];

  always_comb begin
    assert final (!slots[1].valid || !(slot0_op inside {OP_BRANCH, OP_JAL, OP_JALR}))
      else $error("issue_pair: second slot issued behind a control instruction");
  end

endmodule

//--- design/instr_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB is write only with zero wait states. Load only while the core is
// stopped; fetch addresses wrap modulo the memory depth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module instr_mem import rv_pkg::*; (
  input  logic  clock,
  input  logic  reset_n,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  word_t paddr,
  input  word_t pwdata,
  output logic  pready,
  output logic  pslverr,
  input  word_t fetch_pc,
  output word_t fetch_words [LANES]
);

  localparam int IDX_LSB = 2;  // Byte address to word index

  word_t       mem [IMEM_WORDS];
  logic        wr_access;
  logic        in_range;
  imem_index_t wr_index;
  imem_index_t rd_index;

  assign wr_access = psel && penable && pwrite;             // APB access phase
  assign in_range  = (paddr >> IDX_LSB) < IMEM_WORDS;
  assign wr_index  = paddr[IDX_LSB +: $bits(imem_index_t)];
  assign pready    = 1'b1;
  assign pslverr   = wr_access && !in_range;                // Write is dropped

  // Writes held off while the core sits in reset
  always_ff @(posedge clock) begin
    if (wr_access && in_range && reset_n) begin
      mem[wr_index] <= pwdata;
    end
  end

  assign rd_index = fetch_pc[IDX_LSB +: $bits(imem_index_t)];

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      fetch_words[i] = mem[rd_index + imem_index_t'(i)];    // Wraps at depth
    end
  end

endmodule

//--- common/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I integer subset only. No loads, stores, M extension or system ops.
// Lane and slot structs assume LANES is 2 wherever pairing is decided.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

  localparam int IMEM_WORDS = 256;
  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_index_t;

  localparam int LANES = 2;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_NONE   // No result, no write
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
  } issue_slot_t;

  typedef struct packed {
    logic      write_en;
    reg_addr_t rd;
    word_t     wdata;     // ALU value or link address
    logic      redirect;
    word_t     target;    // Bit 0 already cleared
  } lane_result_t;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
  } read_req_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      write;
    reg_addr_t rd;
    word_t     value;
  } retire_t;

endpackage
